/* hdl/cam_target_macros.svh */
//****************************************
// frame size, zone split and orange colour
// thresholds for the target finder
// include wherever the values are needed
//****************************************

`ifndef CAM_TARGET_MACROS_SVH
`define CAM_TARGET_MACROS_SVH

// pixels per line of the frame buffer read-back
`define CT_FRAME_WIDTH 32

// vertical zones per line, one per direction
`define CT_NUM_ZONES 4

// columns per zone
`define CT_ZONE_WIDTH (`CT_FRAME_WIDTH / `CT_NUM_ZONES)

// orange window on the expanded rgb888 channels
`define CT_R_MIN 8'hC0
`define CT_G_MIN 8'h40
`define CT_G_MAX 8'hA0
`define CT_B_MAX 8'h60

// winning count below this means no target
`define CT_MIN_COUNT 6

// zone counter width
`define CT_COUNT_W 16

`endif

/* hdl/cam_target_pkg.sv */
//****************************************
// shared types of the target finder
// pixel words, zone counts, direction and
// the per-frame result record
//****************************************

`include "cam_target_macros.svh"

package cam_target_pkg;

  // raw frame buffer word, red in [11:8]
  typedef logic [11:0] rgb444_t;

  // one expanded colour channel
  typedef logic [7:0] chan_t;

  // column within a line
  typedef logic [$clog2(`CT_FRAME_WIDTH)-1:0] col_t;

  // zone index, 0 is far left
  typedef logic [$clog2(`CT_NUM_ZONES)-1:0] zone_t;

  // orange pixels seen in one zone
  typedef logic [`CT_COUNT_W-1:0] count_t;

  // pixel as it comes from the frame buffer
  // eof only on the last pixel, which also has eol
  typedef struct packed {
    rgb444_t data;
    logic    eol;
    logic    eof;
  } pix_in_t;

  // expanded pixel tagged with its zone
  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
    zone_t zone;
    logic  eof;
  } pix_t;

  // steering direction, zones 0 to 3 in order
  typedef enum logic [2:0] {
    DIR_NONE      = 3'd0,
    DIR_FAR_LEFT  = 3'd1,
    DIR_LEFT      = 3'd2,
    DIR_RIGHT     = 3'd3,
    DIR_FAR_RIGHT = 3'd4
  } dir_t;

  // end of frame report
  typedef struct packed {
    dir_t   direction;
    logic   orange_detected;
    count_t max_count;
  } result_t;

endpackage

/* hdl/pixel_unpack.sv */
//****************************************
// front end of the target finder
// accepts rgb444 words, widens them to
// rgb888 and tags each with its zone
//****************************************

`timescale 1ns/1ps

`include "cam_target_macros.svh"

module pixel_unpack
  import cam_target_pkg::*;
(
  input  logic    clk_25_vga,
  input  logic    arst_n,
  // result pending downstream, stop taking pixels
  input  logic    hold,
  input  logic    pix_in_valid,
  input  pix_in_t pix_in,
  output logic    pix_in_ready,
  output logic    pix_strobe,
  output pix_t    pix
);

  logic  accept;
  col_t  col;
  zone_t zone;

  // only a pending result stalls the input
  assign pix_in_ready = ~hold;
  assign accept       = pix_in_valid & pix_in_ready;

  // zone of the current column
  assign zone = zone_t'(col / `CT_ZONE_WIDTH);

  // column tracking
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      col <= '0;
    end else if (accept) begin
      // eol wraps back to the first column
      if (pix_in.eol) begin
        col <= '0;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // one strobe per accepted pixel
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      pix_strobe <= 1'b0;
    end else begin
      pix_strobe <= accept;
    end
  end

  // payload, loaded only on a transfer
  always_ff @(posedge clk_25_vga) begin
    if (accept) begin
      // nibble repeat, 0xA becomes 0xAA
      pix.red   <= {pix_in.data[11:8], pix_in.data[11:8]};
      pix.green <= {pix_in.data[7:4], pix_in.data[7:4]};
      pix.blue  <= {pix_in.data[3:0], pix_in.data[3:0]};
      pix.zone  <= zone;
      pix.eof   <= pix_in.eof;
    end
  end

endmodule

/* hdl/orange_zone_counter.sv */
//****************************************
// orange pixel counter for one zone
// one instance per zone, all fed by the
// same strobe, count cleared every frame
//****************************************

`timescale 1ns/1ps

`include "cam_target_macros.svh"

module orange_zone_counter
  import cam_target_pkg::*;
#(
  // zone this instance watches, 0 to 3
  parameter int ZONE_ID = 0
) (
  input  logic   clk_25_vga,
  input  logic   arst_n,
  input  logic   pix_strobe,
  input  pix_t   pix,
  output count_t count,
  output logic   frame_done
);

  logic in_zone;
  logic is_orange;
  logic hit;
  logic saturated;

  // pixel belongs to this zone
  assign in_zone = (pix.zone == zone_t'(ZONE_ID));

  // orange window, all bounds inclusive
  assign is_orange = (pix.red >= `CT_R_MIN) &&
                     (pix.green >= `CT_G_MIN) &&
                     (pix.green <= `CT_G_MAX) &&
                     (pix.blue <= `CT_B_MAX);

  assign hit = pix_strobe & in_zone & is_orange;

  // stop at all ones instead of wrapping
  assign saturated = &count;

  // frame_done follows the eof strobe by one edge,
  // the same edge that folds the eof pixel in
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      frame_done <= 1'b0;
    end else begin
      frame_done <= pix_strobe & pix.eof;
    end
  end

  // per-frame count
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (frame_done) begin
      // classifier has sampled, start the next frame
      // a pixel of the next frame may already be here
      if (hit) begin
        count <= count_t'(1);
      end else begin
        count <= '0;
      end
    end else if (hit && !saturated) begin
      count <= count + 1'b1;
    end
  end

endmodule

/* hdl/direction_classifier.sv */
//****************************************
// end of frame decision
// picks the zone with most orange pixels
// and offers it as a valid/ready result
//****************************************

`timescale 1ns/1ps

`include "cam_target_macros.svh"

module direction_classifier
  import cam_target_pkg::*;
(
  input  logic    clk_25_vga,
  input  logic    arst_n,
  // counts are final for the frame
  input  logic    frame_done,
  input  count_t  zone_counts [`CT_NUM_ZONES],
  input  logic    result_ready,
  output logic    result_valid,
  output result_t result,
  // back-pressure towards the unpacker
  output logic    hold
);

  typedef enum logic {
    ST_IDLE,
    ST_PENDING
  } state_t;

  state_t state;
  count_t best_count;
  zone_t  best_zone;
  dir_t   best_dir;
  logic   found;

  // maximum search, strict compare keeps the lowest zone on a tie
  always_comb begin
    best_count = zone_counts[0];
    best_zone  = '0;
    for (int z = 1; z < `CT_NUM_ZONES; z++) begin
      if (zone_counts[z] > best_count) begin
        best_count = zone_counts[z];
        best_zone  = zone_t'(z);
      end
    end
  end

  // too few pixels is no target
  assign found = (best_count >= count_t'(`CT_MIN_COUNT));

  // zone to direction
  always_comb begin
    case (best_zone)
      2'd0:    best_dir = DIR_FAR_LEFT;
      2'd1:    best_dir = DIR_LEFT;
      2'd2:    best_dir = DIR_RIGHT;
      default: best_dir = DIR_FAR_RIGHT;
    endcase
  end

  // result handshake fsm
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (frame_done) begin
            state <= ST_PENDING;
          end
        end
        ST_PENDING: begin
          if (result_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // result record, captured once per frame
  always_ff @(posedge clk_25_vga) begin
    if (state == ST_IDLE && frame_done) begin
      result.direction       <= found ? best_dir : DIR_NONE;
      result.orange_detected <= found;
      result.max_count       <= best_count;
    end
  end

  assign result_valid = (state == ST_PENDING);
  // stalls input for the whole pending time
  assign hold         = (state == ST_PENDING);

endmodule

/* hdl/cam_target_top.sv */
//****************************************
// target finder top level
// pixel stream in, one direction result
// out per frame, single pixel clock
//****************************************

`timescale 1ns/1ps

`include "cam_target_macros.svh"

module cam_target_top
  import cam_target_pkg::*;
(
  input  logic    clk_25_vga,
  input  logic    arst_n,
  input  logic    pix_in_valid,
  input  pix_in_t pix_in,
  output logic    pix_in_ready,
  output logic    result_valid,
  output result_t result,
  input  logic    result_ready
);

  logic                     hold;
  logic                     pix_strobe;
  pix_t                     pix;
  count_t                   zone_counts [`CT_NUM_ZONES];
  // all zones pulse together
  logic [`CT_NUM_ZONES-1:0] zone_done;

  pixel_unpack u_pixel_unpack (
    .clk_25_vga   (clk_25_vga),
    .arst_n       (arst_n),
    .hold         (hold),
    .pix_in_valid (pix_in_valid),
    .pix_in       (pix_in),
    .pix_in_ready (pix_in_ready),
    .pix_strobe   (pix_strobe),
    .pix          (pix)
  );

  // one counter per zone, same pixel to all
  for (genvar i = 0; i < `CT_NUM_ZONES; i++) begin : g_zone
    orange_zone_counter #(
      .ZONE_ID (i)
    ) u_zone (
      .clk_25_vga (clk_25_vga),
      .arst_n     (arst_n),
      .pix_strobe (pix_strobe),
      .pix        (pix),
      .count      (zone_counts[i]),
      .frame_done (zone_done[i])
    );
  end

  // zone 0 pulse stands for all
  direction_classifier u_direction_classifier (
    .clk_25_vga   (clk_25_vga),
    .arst_n       (arst_n),
    .frame_done   (zone_done[0]),
    .zone_counts  (zone_counts),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .result       (result),
    .hold         (hold)
  );

endmodule

/* verification/cam_target_properties.sv */
//****************************************
// handshake assertions, bound into the
// direction classifier by the testbench
//****************************************

`timescale 1ns/1ps

module cam_target_properties
  import cam_target_pkg::*;
(
  input logic    clk_25_vga,
  input logic    arst_n,
  input logic    frame_done,
  input logic    result_valid,
  input logic    result_ready,
  input logic    hold,
  input result_t result
);

  // assertion failures so far
  int fail_count = 0;

  // pending result stays put until taken
  a_result_stable: assert property (
    @(posedge clk_25_vga) disable iff (!arst_n)
    result_valid && !result_ready |=> result_valid && $stable(result)
  ) else begin
    fail_count++;
    $error("result dropped or changed while waiting for ready");
  end

  // nothing offered after reset until a frame has ended
  a_reset_idle: assert property (
    @(posedge clk_25_vga)
    (!arst_n || (!result_valid && !frame_done)) |=> !result_valid
  ) else begin
    fail_count++;
    $error("result_valid high after reset without a frame end");
  end

  // input stalled from the cycle after a frame end
  a_hold_pending: assert property (
    @(posedge clk_25_vga) disable iff (!arst_n)
    frame_done |=> hold
  ) else begin
    fail_count++;
    $error("hold low in the cycle after frame_done");
  end

endmodule

/* verification/cam_target_checker.sv */
//****************************************
// result checker of the testbench
// pops one expected record per accepted
// result and compares every field
//****************************************

`timescale 1ns/1ps

module cam_target_checker
  import cam_target_pkg::*;
(
  input logic    clk_25_vga,
  input logic    arst_n,
  input logic    pix_in_ready,
  input logic    result_valid,
  input logic    result_ready,
  input result_t result
);

  // filled by the testbench top from the stim file
  result_t exp_q [$];
  int      checked      = 0;
  int      pass_count   = 0;
  int      fail_count   = 0;
  int      ready_errors = 0;

  // compare one field and report a difference
  task automatic check_field(input string name, input logic [31:0] want,
                             input logic [31:0] got, input int frame,
                             inout bit bad);
    if (got !== want) begin
      $display("mismatch frame %0d %s: expected 0x%0h, got 0x%0h",
               frame, name, want, got);
      bad = 1'b1;
    end
  endtask

  // a result counts on its accepting edge
  always @(posedge clk_25_vga) begin
    result_t expected;
    bit      bad;
    if (arst_n && result_valid && result_ready) begin
      bad = 1'b0;
      if (exp_q.size() == 0) begin
        $display("frame %0d gave a result with no expected value left", checked + 1);
        fail_count++;
      end else begin
        expected = exp_q.pop_front();
        check_field("direction", 32'(expected.direction), 32'(result.direction),
                    checked + 1, bad);
        check_field("orange_detected", 32'(expected.orange_detected),
                    32'(result.orange_detected), checked + 1, bad);
        check_field("max_count", 32'(expected.max_count), 32'(result.max_count),
                    checked + 1, bad);
        if (bad) begin
          fail_count++;
        end else begin
          $display("frame %0d passed", checked + 1);
          pass_count++;
        end
      end
      checked++;
    end
  end

  // input open with no result out, closed while one waits for ready
  always @(posedge clk_25_vga) begin
    if (!result_valid || !result_ready) begin
      if (pix_in_ready !== !result_valid) begin
        $display("mismatch pix_in_ready: expected 0x%0h, got 0x%0h",
                 !result_valid, pix_in_ready);
        ready_errors++;
      end
    end
  end

endmodule

/* verification/cam_target_tb.sv */
//****************************************
// testbench top of the target finder
// reads frames and expected results from
// the stim file, streams pixels with gaps
// and stalls the result side at random
//****************************************

`timescale 1ns/1ps

module cam_target_tb
  import cam_target_pkg::*;
();

  logic    clk_25_vga;
  logic    arst_n;
  logic    pix_in_valid;
  pix_in_t pix_in;
  logic    pix_in_ready;
  logic    result_valid;
  result_t result;
  logic    result_ready;

  pix_in_t pix_q [$];
  int      pix_idx;
  int      num_exp;
  int      seed;
  int      stall_left;
  int      cycles;
  int      limit;
  logic    run;
  logic    timed_out;

  cam_target_top u_cam_target_top (
    .clk_25_vga   (clk_25_vga),
    .arst_n       (arst_n),
    .pix_in_valid (pix_in_valid),
    .pix_in       (pix_in),
    .pix_in_ready (pix_in_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  cam_target_checker u_checker (
    .clk_25_vga   (clk_25_vga),
    .arst_n       (arst_n),
    .pix_in_ready (pix_in_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
  );

  // handshake assertions on the classifier
  bind direction_classifier cam_target_properties u_props (
    .clk_25_vga   (clk_25_vga),
    .arst_n       (arst_n),
    .frame_done   (frame_done),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .hold         (hold),
    .result       (result)
  );

  // 20 ns pixel clock
  always #10 clk_25_vga = ~clk_25_vga;

  // pixel and result ready driver
  always @(posedge clk_25_vga) begin
    if (run) begin
      // move on once the word is taken or none is offered
      if (!pix_in_valid || pix_in_ready) begin
        if (pix_idx < pix_q.size() && ($random(seed) % 4) != 0) begin
          pix_in_valid <= 1'b1;
          pix_in       <= pix_q[pix_idx];
          pix_idx      <= pix_idx + 1;
        end else begin
          pix_in_valid <= 1'b0;
        end
      end
      // ready stalls of 2 to 17 cycles
      if (stall_left > 0) begin
        result_ready <= 1'b0;
        stall_left   <= stall_left - 1;
      end else if (($random(seed) % 4) == 0) begin
        result_ready <= 1'b0;
        stall_left   <= 2 + ($random(seed) & 15);
      end else begin
        result_ready <= 1'b1;
      end
    end
  end

  initial begin
    int      fd;
    int      code;
    string   kind;
    string   rest;
    int      n;
    int      w;
    int      eol;
    int      eof;
    int      d;
    int      det;
    int      mc;
    pix_in_t p;
    result_t r;
    clk_25_vga   = 1'b0;
    arst_n       = 1'b0;
    pix_in_valid = 1'b0;
    pix_in       = '0;
    result_ready = 1'b0;
    run          = 1'b0;
    seed         = 29;
    pix_idx      = 0;
    stall_left   = 0;
    num_exp      = 0;
    cycles       = 0;
    fd = $fopen("verification/cam_target_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("Test failed");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        if (kind == "p") begin
          code = $fscanf(fd, "%h %h %h %h", n, w, eol, eof);
          // run of n equal words with the flags on the last one
          for (int i = 0; i < n; i++) begin
            p.data = rgb444_t'(w);
            p.eol  = (i == n - 1) && eol[0];
            p.eof  = (i == n - 1) && eof[0];
            pix_q.push_back(p);
          end
        end else if (kind == "e") begin
          code = $fscanf(fd, "%h %h %h", d, det, mc);
          r.direction       = dir_t'(d);
          r.orange_detected = det[0];
          r.max_count       = count_t'(mc);
          u_checker.exp_q.push_back(r);
          num_exp++;
        end else begin
          code = $fgets(rest, fd);
        end
      end
      $fclose(fd);
      // bound covers gaps and stalls
      limit = 4 * pix_q.size() + 200;
      repeat (10) @(posedge clk_25_vga);
      arst_n <= 1'b1;
      run    <= 1'b1;
      while (u_checker.checked < num_exp && cycles < limit) begin
        @(posedge clk_25_vga);
        cycles++;
      end
      timed_out = (u_checker.checked < num_exp);
      if (timed_out) begin
        $display("timeout after %0d cycles, only %0d of %0d frame results arrived",
                 cycles, u_checker.checked, num_exp);
      end
      $display("frames %0d, passed %0d, failed %0d, ready errors %0d, assertion failures %0d",
               u_checker.checked, u_checker.pass_count, u_checker.fail_count,
               u_checker.ready_errors,
               u_cam_target_top.u_direction_classifier.u_props.fail_count);
      if (!timed_out && u_checker.fail_count == 0 && u_checker.ready_errors == 0 &&
          u_cam_target_top.u_direction_classifier.u_props.fail_count == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

/* verification/cam_target_stim.txt */
# p count word eol eof : run of count equal pixels, eol and eof apply to the last one
# e direction orange_detected max_count : expected result of the frame above, all hex
p 10 000 0 0
p 08 F80 0 0
p 08 000 1 0
p 10 000 0 0
p 08 F80 0 0
p 08 000 1 1
e 3 1 10
p 02 C75 0 0
p 02 F45 0 0
p 02 F95 0 0
p 02 F75 0 0
p 02 B75 0 0
p 02 F35 0 0
p 02 FA5 0 0
p 02 F76 0 0
p 10 000 1 1
e 1 1 08
p 05 F80 0 0
p 18 000 0 0
p 03 F80 1 1
e 0 0 05
p 07 F80 0 0
p 01 000 0 0
p 04 F80 0 0
p 04 000 0 0
p 07 F80 0 0
p 09 000 1 1
e 1 1 07
p 18 000 0 0
p 08 E60 1 0
p 04 E60 0 0
p 14 000 0 0
p 08 E60 1 1
e 4 1 10
p 08 000 0 0
p 06 F80 0 0
p 12 000 1 1
e 2 1 06

/* cam_target_top.f */
+incdir+hdl
hdl/cam_target_pkg.sv
hdl/pixel_unpack.sv
hdl/orange_zone_counter.sv
hdl/direction_classifier.sv
hdl/cam_target_top.sv
verification/cam_target_properties.sv
verification/cam_target_checker.sv
verification/cam_target_tb.sv

/* Bender.yml */
package:
  name: cam_target

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/cam_target_pkg.sv
      - hdl/pixel_unpack.sv
      - hdl/orange_zone_counter.sv
      - hdl/direction_classifier.sv
      - hdl/cam_target_top.sv
  - target: test
    files:
      - verification/cam_target_properties.sv
      - verification/cam_target_checker.sv
      - verification/cam_target_tb.sv
